/* design/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// process contexts, all resident
`define NUM_PROC 4
`define PROC_W 2 // index bits, NUM_PROC is a power of two

// register file per process
`define NUM_REGS 8
`define REG_SEL_W 3 // low bits of the reg field pick the register
`define REG_FIELD_W 8 // reg field as encoded in the word
`define DATA_W 16 // registers and immediates

// instruction word is op | reg | imm
`define OP_W 8
`define INSTR_W 32

// program memory, 256 words split into equal spans
`define PROG_AW 8
`define PROC_SPAN 64 // base pc of process p is p * span

// scheduling and trace flow control
`define SLICE_LEN 3 // instructions per time slice
`define SLICE_W 2
`define TRACE_CREDITS 4 // credits held after reset
`define CREDIT_W 3 // counts 0..TRACE_CREDITS

`endif

/* design/cpu_pkg.sv */
`include "cpu_macros.svh"

package cpu_pkg;

  // kept opcodes, anything else runs as a no-op
  typedef enum logic [`OP_W-1:0] {
    OP_JMP       = 1,  // absolute jump
    OP_NUM2REG   = 4,  // reg = imm
    OP_REG_PLUS  = 5,  // reg += imm
    OP_REG_MINUS = 6,  // reg -= imm
    OP_EXIT      = 17  // process ends
  } opcode_e;

  // scheduler fsm
  typedef enum logic [2:0] {
    S_IDLE,   // waiting for start
    S_FETCH,  // pc to memory, holds while out of credits
    S_EXEC,   // issue to the current context
    S_SWITCH, // pick next active process
    S_HALT    // nothing left to run
  } sched_state_e;

endpackage

/* design/ctx_if.sv */
`include "cpu_macros.svh"

interface ctx_if;
  import cpu_pkg::*;

  // scheduler to contexts
  logic                     start;       // one cycle, arms every context
  logic                     issue_valid; // one instruction this cycle
  logic [`PROC_W-1:0]       issue_proc;  // target context
  opcode_e                  issue_op;
  logic [`REG_FIELD_W-1:0]  issue_reg;
  logic [`DATA_W-1:0]       issue_imm;

  // contexts back, element k belongs to context k
  logic [`PROG_AW-1:0]      pc_bus [`NUM_PROC];
  logic [`NUM_PROC-1:0]     active_vec;
  logic [`NUM_PROC-1:0]     res_valid;   // one cycle after issue
  logic [`DATA_W-1:0]       res_value [`NUM_PROC];

  // trace drain to scheduler
  logic                     credit_avail;

  modport sched (
    output start, issue_valid, issue_proc, issue_op, issue_reg, issue_imm,
    input  pc_bus, active_vec, credit_avail
  );

  modport ctx (
    input  start, issue_valid, issue_proc, issue_op, issue_reg, issue_imm,
    output pc_bus, active_vec, res_valid, res_value
  );

  // trace drain only needs the record fields, not the immediate
  modport mon (
    input  issue_valid, issue_proc, issue_op, issue_reg, res_valid, res_value,
    output credit_avail
  );

endinterface

/* design/prog_mem.sv */
`include "cpu_macros.svh"

module prog_mem (
  input  logic                  clka,
  input  logic                  load_en,    // one word per cycle
  input  logic [`PROG_AW-1:0]   load_addr,
  input  logic [`INSTR_W-1:0]   load_data,
  input  logic [`PROG_AW-1:0]   fetch_addr,
  output logic [`INSTR_W-1:0]   fetch_word  // valid one cycle after fetch_addr
);

  logic [`INSTR_W-1:0] mem [2**`PROG_AW]; // 256 x 32

  // load port, used before start
  always_ff @(posedge clka) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // registered read, one cycle latency
  always_ff @(posedge clka) begin
    fetch_word <= mem[fetch_addr];
  end

endmodule

/* design/task_scheduler.sv */
`include "cpu_macros.svh"

module task_scheduler (
  input  logic                  clka,
  input  logic                  rst,
  input  logic                  start,
  input  logic [`INSTR_W-1:0]   fetch_word,
  output logic [`PROG_AW-1:0]   fetch_addr,
  output logic                  done,
  ctx_if.sched                  bus
);
  import cpu_pkg::*;

  sched_state_e           state;
  logic [`PROC_W-1:0]     cur_proc;   // process owning the slice
  logic [`SLICE_W-1:0]    slice_cnt;  // issues so far in this slice
  logic [`PROC_W-1:0]     nxt_proc;
  logic                   nxt_found;
  logic                   slice_end;

  // fetch always follows the current process pc
  assign fetch_addr = bus.pc_bus[cur_proc];

  // start only counts while idle
  assign bus.start = start && (state == S_IDLE);

  // decode the fetched word, valid in EXEC
  assign bus.issue_valid = (state == S_EXEC);
  assign bus.issue_proc  = cur_proc;
  assign bus.issue_op    = opcode_e'(fetch_word[`INSTR_W-1 -: `OP_W]);
  assign bus.issue_reg   = fetch_word[`DATA_W +: `REG_FIELD_W];
  assign bus.issue_imm   = fetch_word[`DATA_W-1:0];

  assign done = (state == S_HALT); // held until reset

  // slice over after SLICE_LEN issues or on exit
  assign slice_end = (bus.issue_op == OP_EXIT) ||
                     (slice_cnt == `SLICE_W'(`SLICE_LEN - 1));

  // round robin search, starts after cur_proc and ends on it
  always_comb begin
    logic [`PROC_W-1:0] cand;
    nxt_found = 1'b0;
    nxt_proc  = cur_proc;
    for (int i = 1; i <= `NUM_PROC; i++) begin
      cand = cur_proc + `PROC_W'(i); // wraps by width
      if (!nxt_found && bus.active_vec[cand]) begin
        nxt_found = 1'b1;
        nxt_proc  = cand;
      end
    end
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      state     <= S_IDLE;
      cur_proc  <= '0;
      slice_cnt <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            state     <= S_FETCH; // contexts go active on this edge
            cur_proc  <= '0;
            slice_cnt <= '0;
          end
        end
        S_FETCH: begin
          if (bus.credit_avail) begin
            state <= S_EXEC; // word arrives next cycle
          end
        end
        S_EXEC: begin
          if (slice_end) begin
            state     <= S_SWITCH;
            slice_cnt <= '0;
          end else begin
            state     <= S_FETCH;
            slice_cnt <= slice_cnt + 1'b1;
          end
        end
        S_SWITCH: begin
          // active_vec already shows an exit from the last issue
          if (nxt_found) begin
            state    <= S_FETCH;
            cur_proc <= nxt_proc;
          end else begin
            state <= S_HALT;
          end
        end
        S_HALT: state <= S_HALT;
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

/* design/process_ctx.sv */
`include "cpu_macros.svh"

module process_ctx #(
  parameter int IDX = 0 // context number
) (
  input  logic clka,
  input  logic rst,
  ctx_if.ctx   bus
);
  import cpu_pkg::*;

  localparam logic [`PROG_AW-1:0] BASE_PC = `PROG_AW'(IDX * `PROC_SPAN);

  logic [`PROG_AW-1:0]    pc;
  logic [`DATA_W-1:0]     regs [`NUM_REGS];
  logic                   active;
  logic                   res_valid_q;
  logic [`DATA_W-1:0]     res_value_q;
  logic                   hit;        // instruction is ours
  logic [`REG_SEL_W-1:0]  rsel;
  logic [`DATA_W-1:0]     cur_val;
  logic [`DATA_W-1:0]     new_val;
  logic                   reg_wr;

  assign hit     = bus.issue_valid && (bus.issue_proc == `PROC_W'(IDX));
  assign rsel    = bus.issue_reg[`REG_SEL_W-1:0]; // upper bits ignored
  assign cur_val = regs[rsel];

  // own slot of the shared vectors
  assign bus.pc_bus[IDX]     = pc;
  assign bus.active_vec[IDX] = active;
  assign bus.res_valid[IDX]  = res_valid_q;
  assign bus.res_value[IDX]  = res_value_q;

  // alu and result select
  always_comb begin
    reg_wr  = 1'b0;
    new_val = cur_val; // no-op reports the register as is
    case (bus.issue_op)
      OP_NUM2REG: begin
        reg_wr  = 1'b1;
        new_val = bus.issue_imm;
      end
      OP_REG_PLUS: begin
        reg_wr  = 1'b1;
        new_val = cur_val + bus.issue_imm; // wraps mod 2^16
      end
      OP_REG_MINUS: begin
        reg_wr  = 1'b1;
        new_val = cur_val - bus.issue_imm;
      end
      OP_JMP:  new_val = `DATA_W'(bus.issue_imm[`PROG_AW-1:0]); // new pc
      OP_EXIT: new_val = '0;
      default: new_val = cur_val;
    endcase
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      pc          <= BASE_PC;
      active      <= 1'b0;
      res_valid_q <= 1'b0;
      for (int r = 0; r < `NUM_REGS; r++) begin
        regs[r] <= '0; // first plus or minus starts from zero
      end
    end else begin
      res_valid_q <= hit;
      if (bus.start) begin
        active <= 1'b1;
        pc     <= BASE_PC;
      end else if (hit) begin
        if (reg_wr) begin
          regs[rsel] <= new_val;
        end
        case (bus.issue_op)
          OP_JMP:  pc <= bus.issue_imm[`PROG_AW-1:0];
          OP_EXIT: active <= 1'b0; // pc left where it is
          default: pc <= pc + 1'b1;
        endcase
      end
    end
  end

  // result payload, read only with res_valid
  always_ff @(posedge clka) begin
    if (hit) begin
      res_value_q <= new_val;
    end
  end

endmodule

/* design/trace_out.sv */
`include "cpu_macros.svh"

module trace_out (
  input  logic                      clka,
  input  logic                      rst,
  input  logic                      credit_return,  // one credit per high cycle
  ctx_if.mon                        bus,
  output logic                      trace_valid,
  output logic [`PROC_W-1:0]        trace_proc,
  output cpu_pkg::opcode_e          trace_op,
  output logic [`REG_FIELD_W-1:0]   trace_reg,
  output logic [`DATA_W-1:0]        trace_value
);
  import cpu_pkg::*;

  logic                       pend_valid;  // issued last cycle, result due now
  logic [`PROC_W-1:0]         pend_proc;
  opcode_e                    pend_op;
  logic [`REG_FIELD_W-1:0]    pend_reg;
  logic [`CREDIT_W-1:0]       credit_cnt;

  assign bus.credit_avail = (credit_cnt != '0);

  // credits: issue takes one, return gives one back
  always_ff @(posedge clka) begin
    if (!rst) begin
      credit_cnt <= `CREDIT_W'(`TRACE_CREDITS);
    end else begin
      case ({credit_return, bus.issue_valid})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt; // both or neither
      endcase
    end
  end

  // control of both stages
  always_ff @(posedge clka) begin
    if (!rst) begin
      pend_valid  <= 1'b0;
      trace_valid <= 1'b0;
    end else begin
      pend_valid  <= bus.issue_valid;
      trace_valid <= pend_valid && bus.res_valid[pend_proc];
    end
  end

  // stage 1 holds the issue fields, stage 2 adds the context result
  always_ff @(posedge clka) begin
    if (bus.issue_valid) begin
      pend_proc <= bus.issue_proc;
      pend_op   <= bus.issue_op;
      pend_reg  <= bus.issue_reg;
    end
    if (pend_valid) begin
      trace_proc  <= pend_proc;
      trace_op    <= pend_op;
      trace_reg   <= pend_reg;
      trace_value <= bus.res_value[pend_proc];
    end
  end

endmodule

/* design/cpu_top.sv */
`include "cpu_macros.svh"

module cpu_top (
  input  logic                      clka,
  input  logic                      rst,
  input  logic                      load_en,
  input  logic [`PROG_AW-1:0]       load_addr,
  input  logic [`INSTR_W-1:0]       load_data,
  input  logic                      start,          // pulse while idle
  input  logic                      credit_return,
  output logic                      trace_valid,    // must be accepted
  output logic [`PROC_W-1:0]        trace_proc,
  output cpu_pkg::opcode_e          trace_op,
  output logic [`REG_FIELD_W-1:0]   trace_reg,
  output logic [`DATA_W-1:0]        trace_value,
  output logic                      done
);

  logic [`PROG_AW-1:0] fetch_addr;
  logic [`INSTR_W-1:0] fetch_word;

  ctx_if bus (); // scheduler, contexts and trace drain

  prog_mem i_prog_mem (
    .clka       (clka),
    .load_en    (load_en),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .fetch_addr (fetch_addr),
    .fetch_word (fetch_word)
  );

  task_scheduler i_task_scheduler (
    .clka       (clka),
    .rst        (rst),
    .start      (start),
    .fetch_word (fetch_word),
    .fetch_addr (fetch_addr),
    .done       (done),
    .bus        (bus.sched)
  );

  // one resident context per process
  for (genvar k = 0; k < `NUM_PROC; k++) begin : g_ctx
    process_ctx #(
      .IDX (k)
    ) i_process_ctx (
      .clka (clka),
      .rst  (rst),
      .bus  (bus.ctx)
    );
  end

  trace_out i_trace_out (
    .clka          (clka),
    .rst           (rst),
    .credit_return (credit_return),
    .bus           (bus.mon),
    .trace_valid   (trace_valid),
    .trace_proc    (trace_proc),
    .trace_op      (trace_op),
    .trace_reg     (trace_reg),
    .trace_value   (trace_value)
  );

endmodule

/* test/cpu_assert.sv */
`include "cpu_macros.svh"

module cpu_assert (
  input logic                   clka,
  input logic                   rst,
  input logic                   trace_valid,
  input logic [`PROC_W-1:0]     trace_proc,
  input logic                   done,
  input logic [`CREDIT_W-1:0]   credit_cnt,   // held in trace_out
  input cpu_pkg::sched_state_e  sched_state,
  input logic [`PROC_W-1:0]     issue_proc    // process in the issue slot
);
  import cpu_pkg::*;

  // sync reset clears the trace stage on the same edge
  a_no_trace_in_reset: assert property (@(posedge clka) !rst |=> !trace_valid)
    else $error("trace_valid was high while reset was held");

  // record belongs to the issue two cycles back, so always a real process
  a_proc_issued: assert property (@(posedge clka) disable iff (!rst)
    trace_valid |-> ($past(sched_state, 2) == S_EXEC) &&
                    (trace_proc == $past(issue_proc, 2)))
    else $error("trace record does not match the process issued two cycles earlier");

  // last record may coincide with done, nothing later
  a_quiet_after_done: assert property (@(posedge clka) disable iff (!rst)
    (done && $past(done)) |-> !trace_valid)
    else $error("trace_valid rose after done had been high for two cycles");

  a_credit_bound: assert property (@(posedge clka) disable iff (!rst)
    credit_cnt <= `CREDIT_W'(`TRACE_CREDITS))
    else $error("credit counter went above its reset value");

  a_issue_has_credit: assert property (@(posedge clka) disable iff (!rst)
    (sched_state == S_EXEC) |-> (credit_cnt != '0))
    else $error("instruction issued while no trace credit was left");

endmodule

bind cpu_top cpu_assert i_cpu_assert (
  .clka        (clka),
  .rst         (rst),
  .trace_valid (trace_valid),
  .trace_proc  (trace_proc),
  .done        (done),
  .credit_cnt  (i_trace_out.credit_cnt),
  .sched_state (i_task_scheduler.state),
  .issue_proc  (i_task_scheduler.cur_proc)
);

/* test/cpu_tb.sv */
`include "cpu_macros.svh"

module cpu_tb;
  import cpu_pkg::*;

  logic                     clka;
  logic                     rst;
  logic                     load_en;
  logic [`PROG_AW-1:0]      load_addr;
  logic [`INSTR_W-1:0]      load_data;
  logic                     start;
  logic                     credit_return;
  logic                     trace_valid;
  logic [`PROC_W-1:0]       trace_proc;
  opcode_e                  trace_op;
  logic [`REG_FIELD_W-1:0]  trace_reg;
  logic [`DATA_W-1:0]       trace_value;
  logic                     done;

  logic [31:0]              lfsr_q;                 // galois state
  logic [`INSTR_W-1:0]      prog [2**`PROG_AW];     // copy of the loaded program
  int                       load_list [$];          // word addresses, load order
  logic [33:0]              exp_q [$];              // {proc, op, reg, value}
  int                       rec_cnt;                // monitor side
  int                       returned;               // credits handed back
  int                       cycles;
  int                       limit;
  bit                       running;
  bit                       done_seen;

  cpu_top i_cpu_top (
    .clka          (clka),
    .rst           (rst),
    .load_en       (load_en),
    .load_addr     (load_addr),
    .load_data     (load_data),
    .start         (start),
    .credit_return (credit_return),
    .trace_valid   (trace_valid),
    .trace_proc    (trace_proc),
    .trace_op      (trace_op),
    .trace_reg     (trace_reg),
    .trace_value   (trace_value),
    .done          (done)
  );

  always begin
    clka = 1'b0;
    #20;
    clka = 1'b1;
    #20;
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  // one lfsr step per bit, newest bit ends up in bit 0
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  // per span: 5..20 random words, then exit
  task automatic gen_program();
    int          n;
    int          base;
    int          kind;
    logic [7:0]  op;
    logic [7:0]  rg;
    logic [15:0] imm;
    for (int p = 0; p < `NUM_PROC; p++) begin
      base = p * `PROC_SPAN;
      n    = 5 + int'(next_bits(4)); // redrawn per process
      for (int i = 0; i < n; i++) begin
        kind = int'(next_bits(3));
        rg   = 8'(next_bits(8)); // upper bits unused by the core
        imm  = 16'(next_bits(16));
        case (kind)
          0, 5: op = OP_NUM2REG;
          1, 6: op = OP_REG_PLUS;
          2, 7: op = OP_REG_MINUS;
          3:    op = 8'h00; // no-op
          default: begin
            op  = OP_JMP; // forward only, lands at most on the exit
            imm = 16'(base + i + 1 + int'(next_bits(5)) % (n - i));
          end
        endcase
        prog[base + i] = {op, rg, imm};
        load_list.push_back(base + i);
      end
      prog[base + n] = {8'(OP_EXIT), 8'(next_bits(8)), 16'(next_bits(16))};
      load_list.push_back(base + n);
    end
  endtask

  // reference model, every context resident, round robin slices
  task automatic build_expected();
    logic [`PROG_AW-1:0]  pc [`NUM_PROC];
    logic [`DATA_W-1:0]   regs [`NUM_PROC][`NUM_REGS];
    bit                   act [`NUM_PROC];
    logic [`INSTR_W-1:0]  w;
    logic [7:0]           op;
    logic [2:0]           r;
    logic [`DATA_W-1:0]   val;
    int                   cur;
    int                   cnt;
    int                   nxt;
    bit                   slice_open;
    for (int p = 0; p < `NUM_PROC; p++) begin
      pc[p]  = `PROG_AW'(p * `PROC_SPAN);
      act[p] = 1'b1;
      for (int k = 0; k < `NUM_REGS; k++) begin
        regs[p][k] = '0; // reset value
      end
    end
    cur = 0;
    while (cur >= 0) begin
      cnt        = 0;
      slice_open = 1'b1;
      while (slice_open) begin
        w   = prog[pc[cur]];
        op  = w[31:24];
        r   = w[18:16]; // low reg bits only
        val = regs[cur][r];
        case (op)
          OP_NUM2REG:   val = w[15:0];
          OP_REG_PLUS:  val = val + w[15:0]; // mod 2^16
          OP_REG_MINUS: val = val - w[15:0];
          OP_JMP:       val = {8'h00, w[7:0]};
          OP_EXIT:      val = '0;
          default:      val = regs[cur][r];
        endcase
        if (op == OP_NUM2REG || op == OP_REG_PLUS || op == OP_REG_MINUS) begin
          regs[cur][r] = val;
        end
        if (op == OP_JMP) begin
          pc[cur] = w[7:0];
        end else if (op == OP_EXIT) begin
          act[cur] = 1'b0;
        end else begin
          pc[cur] = pc[cur] + 8'd1;
        end
        exp_q.push_back({2'(cur), op, w[23:16], val});
        cnt++;
        slice_open = (op != OP_EXIT) && (cnt < `SLICE_LEN);
      end
      nxt = -1; // next active after cur, cur itself last
      for (int i = 1; i <= `NUM_PROC; i++) begin
        if (nxt < 0 && act[(cur + i) % `NUM_PROC]) begin
          nxt = (cur + i) % `NUM_PROC;
        end
      end
      cur = nxt; // -1 once all exited
    end
  endtask

  function automatic string value_test(input logic [7:0] op);
    case (op)
      OP_NUM2REG, OP_REG_PLUS, OP_REG_MINUS: return "register_ops";
      OP_JMP:  return "jump";
      OP_EXIT: return "exit";
      default: return "noop";
    endcase
  endfunction

  task automatic check_record();
    logic [33:0] e;
    logic [7:0]  act_op;
    act_op = trace_op;
    assert (rec_cnt < exp_q.size())
      else stop_on_error("more trace records arrived than the program executes");
    e = exp_q[rec_cnt];
    assert (trace_proc == e[33:32]) else stop_on_error($sformatf(
      "mismatch round_robin record %0d: expected %0d actual %0d", rec_cnt, e[33:32], trace_proc));
    assert (act_op == e[31:24]) else stop_on_error($sformatf(
      "mismatch fetch_order record %0d op: expected %h actual %h", rec_cnt, e[31:24], act_op));
    assert (trace_reg == e[23:16]) else stop_on_error($sformatf(
      "mismatch fetch_order record %0d reg: expected %h actual %h", rec_cnt, e[23:16], trace_reg));
    assert (trace_value == e[15:0]) else stop_on_error($sformatf(
      "mismatch %s record %0d: expected %h actual %h",
      value_test(e[31:24]), rec_cnt, e[15:0], trace_value));
    rec_cnt++;
    assert (rec_cnt <= returned + `TRACE_CREDITS) else stop_on_error($sformatf(
      "mismatch credits: expected at most %0d records actual %0d",
      returned + `TRACE_CREDITS, rec_cnt));
  endtask

  // outputs sampled mid cycle
  always @(negedge clka) begin
    if (running) begin
      if (trace_valid) begin
        assert (!done_seen) else stop_on_error("a trace record arrived after done was raised");
        check_record();
      end
      if (done && !done_seen) begin
        done_seen = 1'b1;
        assert (rec_cnt == exp_q.size()) else stop_on_error($sformatf(
          "mismatch completion: expected %0d records actual %0d", exp_q.size(), rec_cnt));
      end
    end
  end

  always @(posedge clka) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      stop_on_error($sformatf("timeout, run not finished after %0d cycles", cycles));
    end
  end

  initial begin
    bit coin;
    rst           = 1'b0;
    load_en       = 1'b0;
    load_addr     = '0;
    load_data     = '0;
    start         = 1'b0;
    credit_return = 1'b0;
    running       = 1'b0;
    lfsr_q        = 32'h196f_b5cd;
    gen_program();
    build_expected();
    // 8 per word for execution, plus load, reset and slack
    limit = 8 * load_list.size() + load_list.size() + 16 + 200;
    repeat (16) @(posedge clka);
    #5;
    rst = 1'b1;
    foreach (load_list[i]) begin // one word per cycle
      @(posedge clka);
      #5;
      load_en   = 1'b1;
      load_addr = `PROG_AW'(load_list[i]);
      load_data = prog[load_list[i]];
    end
    @(posedge clka);
    #5;
    load_en = 1'b0;
    start   = 1'b1;
    running = 1'b1;
    @(posedge clka);
    #5;
    start = 1'b0;
    while (!done_seen) begin
      coin          = (next_bits(1) != 0);
      credit_return = (rec_cnt > returned) && coin; // only credits already earned
      if (credit_return) begin
        returned++;
      end
      @(posedge clka);
      #5;
    end
    credit_return = 1'b0;
    repeat (4) @(posedge clka); // catch stray records after done
    if (rec_cnt == exp_q.size()) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      stop_on_error($sformatf("mismatch completion: expected %0d records actual %0d",
        exp_q.size(), rec_cnt));
    end
  end

endmodule

/* filelist.f */
+incdir+design
design/cpu_pkg.sv
design/ctx_if.sv
design/prog_mem.sv
design/task_scheduler.sv
design/process_ctx.sv
design/trace_out.sv
design/cpu_top.sv
test/cpu_assert.sv
test/cpu_tb.sv

/* run.sh */
#!/bin/sh
# compile with verilator, run, then scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module cpu_tb -f filelist.f -o cpu_sim

./obj_dir/cpu_sim | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failure"
